/* source/multu_pkg.sv */
// multu shared package with the default operand width and the control enums
package multu_pkg;

  // operand width that the top level uses unless it is overridden
  parameter int multu_width_default = 32;

  // states of the control FSM
  // each multiplier bit costs one ST_ADD cycle followed by one ST_SHIFT cycle
  typedef enum logic [2:0]
  {
    ST_IDLE  = 3'd0, // waiting for a start pulse from the request block
    ST_LOAD  = 3'd1, // datapath copies the operands into its registers
    ST_ADD   = 3'd2, // add the multiplicand or zero into the upper half
    ST_SHIFT = 3'd3, // shift the product register right by one
    ST_DONE  = 3'd4  // all shifts are finished and done is raised
  } multu_state_e;

  // step opcode that the control hands to the datapath every cycle
  // the datapath does nothing on its own and only follows this opcode
  typedef enum logic [1:0]
  {
    STEP_HOLD  = 2'd0, // keep every datapath register as it is
    STEP_LOAD  = 2'd1, // multiplier to the low half and zeros to the high half
    STEP_ADD   = 2'd2, // conditional add selected by the product lsb
    STEP_SHIFT = 2'd3  // shift right with the carry bit moving down
  } multu_step_e;

endpackage

/* source/multu_request_regs.sv */
// multu request block running the four-phase req/ack handshake and holding the operands
`timescale 1ns/1ps

module multu_request_regs
  import multu_pkg::*;
#(
  parameter int WIDTH = multu_width_default
)
(
  input  logic             doMult,
  input  logic             rst_n,
  input  logic             req,             // request level from the outside
  input  logic [WIDTH-1:0] multiplicand_in, // operands as presented with req
  input  logic [WIDTH-1:0] multiplier_in,
  input  logic             done,            // control has finished the last shift
  output logic             ack,             // acknowledge back to the outside
  output logic             start,           // single cycle launch for the control
  output logic [WIDTH-1:0] multiplicand,    // captured operands for the datapath
  output logic [WIDTH-1:0] multiplier
);

  // where the handshake currently stands
  typedef enum logic [1:0]
  {
    PH_IDLE  = 2'd0, // ack is low and a new req may be taken
    PH_BUSY  = 2'd1, // a multiply is running in the control and datapath
    PH_ACKED = 2'd2  // ack is high and we wait for req to drop
  } phase_e;

  phase_e phase;
  logic   accept;    // req is taken on this edge
  logic   finish;    // the running multiply has ended on this edge

  // only an idle block with ack already low may take a new request
  assign accept = (phase == PH_IDLE) && req && !ack;

  // done from the previous multiply is still high in the cycle that start is out
  // because the control only clears it when it sees start, so that cycle is skipped
  assign finish = (phase == PH_BUSY) && done && !start;

  always_ff @(posedge doMult or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase <= PH_IDLE;
      ack   <= 1'b0;
      start <= 1'b0;
    end
    else
    begin
      start <= accept; // high for exactly one cycle after acceptance
      case (phase)
        PH_IDLE:
        begin
          if (accept)
            phase <= PH_BUSY;
        end
        PH_BUSY:
        begin
          if (finish)
          begin
            phase <= PH_ACKED;
            ack   <= 1'b1; // the product register is settled by now
          end
        end
        PH_ACKED:
        begin
          // ack stays up as long as the outside keeps req high
          if (!req)
          begin
            phase <= PH_IDLE;
            ack   <= 1'b0;
          end
        end
        default:
        begin
          phase <= PH_IDLE;
          ack   <= 1'b0;
        end
      endcase
    end
  end

  // operand registers carry payload only and are written on acceptance
  always_ff @(posedge doMult)
  begin
    if (accept)
    begin
      multiplicand <= multiplicand_in;
      multiplier   <= multiplier_in;
    end
  end

  // ack may only come up in answer to a request that is still present
  ack_needs_req: assert property (@(posedge doMult) disable iff (!rst_n)
    $rose(ack) |-> $past(req));

  // after a launch no second launch happens until the first one is acknowledged
  no_start_while_busy: assert property (@(posedge doMult) disable iff (!rst_n)
    start |=> (!start throughout ack [->1]));

endmodule

/* source/multu_control.sv */
// multu control FSM sequencing load, add and shift steps and counting the shifts
`timescale 1ns/1ps

module multu_control
  import multu_pkg::*;
#(
  parameter int WIDTH = multu_width_default // number of shift steps per multiply
)
(
  input  logic        doMult,
  input  logic        rst_n,
  input  logic        start, // launch pulse from the request block
  output multu_step_e step,  // opcode for the datapath in this cycle
  output logic        done   // stays high from the end of a multiply until the next start
);

  // one extra bit so the counter can hold WIDTH itself
  localparam int CNT_W = $clog2(WIDTH) + 1;

  // count value seen during the last shift and the value left behind by it
  localparam logic [CNT_W-1:0] LAST_SHIFT = CNT_W'(WIDTH - 1);
  localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(WIDTH);

  multu_state_e     state;
  multu_state_e     state_nxt;
  logic [CNT_W-1:0] shift_cnt; // shifts completed since the last start

  // next state logic
  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:
      begin
        if (start)
          state_nxt = ST_LOAD;
      end
      ST_LOAD:  state_nxt = ST_ADD;
      ST_ADD:   state_nxt = ST_SHIFT; // every add is paired with a shift
      ST_SHIFT:
      begin
        // the counter still shows the old value during the shift cycle
        if (shift_cnt == LAST_SHIFT)
          state_nxt = ST_DONE;
        else
          state_nxt = ST_ADD;
      end
      ST_DONE:  state_nxt = ST_IDLE;
      default:  state_nxt = ST_IDLE;
    endcase
  end

  // the opcode is decoded straight from the state so the datapath acts
  // on the edge that ends the matching state
  always_comb
  begin
    case (state)
      ST_LOAD:  step = STEP_LOAD;
      ST_ADD:   step = STEP_ADD;   // the datapath picks multiplicand or zero from its lsb
      ST_SHIFT: step = STEP_SHIFT;
      default:  step = STEP_HOLD;  // idle and done leave the product untouched
    endcase
  end

  always_ff @(posedge doMult or negedge rst_n)
  begin
    if (!rst_n)
      state <= ST_IDLE;
    else
      state <= state_nxt;
  end

  // shift counter clears on start and steps once per shift
  always_ff @(posedge doMult or negedge rst_n)
  begin
    if (!rst_n)
      shift_cnt <= '0;
    else if (state == ST_IDLE && start)
      shift_cnt <= '0;
    else if (state == ST_SHIFT)
      shift_cnt <= shift_cnt + 1'b1;
  end

  // done is registered out of ST_DONE which gives the request block
  // a full cycle of settled product before it raises ack
  always_ff @(posedge doMult or negedge rst_n)
  begin
    if (!rst_n)
      done <= 1'b0;
    else if (state == ST_IDLE && start)
      done <= 1'b0;
    else if (state == ST_DONE)
      done <= 1'b1;
  end

  // an add only happens while multiplier bits are left and it is never left without its shift
  add_then_shift: assert property (@(posedge doMult) disable iff (!rst_n)
    (step == STEP_ADD) |-> (shift_cnt < FULL_COUNT) ##1 (step == STEP_SHIFT));

  // the multiply only ends once every multiplier bit has been shifted out
  done_after_all_shifts: assert property (@(posedge doMult) disable iff (!rst_n)
    $rose(done) |-> (shift_cnt == FULL_COUNT));

endmodule

/* source/multu_datapath.sv */
// multu datapath with the multiplicand register, the carry-extended product register and the adder
`timescale 1ns/1ps

module multu_datapath
  import multu_pkg::*;
#(
  parameter int WIDTH = multu_width_default
)
(
  input  logic               doMult,
  input  logic               rst_n,
  input  multu_step_e        step,         // opcode from the control
  input  logic [WIDTH-1:0]   multiplicand, // captured operands from the request block
  input  logic [WIDTH-1:0]   multiplier,
  output logic [2*WIDTH-1:0] product       // result without the carry bit
);

  // layout of the product register
  //   bit 2*WIDTH              carry out of the last add
  //   bits 2*WIDTH-1..WIDTH    running partial sum
  //   bits WIDTH-1..0          multiplier bits not yet consumed
  localparam int PW = 2 * WIDTH + 1;

  logic [PW-1:0]    prod_q;
  logic [WIDTH-1:0] mcand_q;   // multiplicand kept for the whole multiply
  logic             prod_lsb;  // multiplier bit that the current add works on
  logic [WIDTH:0]   addend;    // multiplicand or zero with a leading zero
  logic [WIDTH:0]   sum;       // WIDTH+1 bit adder result with carry on top

  assign prod_lsb = prod_q[0];

  // a clear lsb turns the add into adding zero
  assign addend = prod_lsb ? {1'b0, mcand_q} : '0;

  // the carry bit is always clear before an add since the shift before it
  // moved a zero into the top
  assign sum = {1'b0, prod_q[2*WIDTH-1:WIDTH]} + addend;

  // product register is the visible result so it comes out of reset cleared
  always_ff @(posedge doMult or negedge rst_n)
  begin
    if (!rst_n)
      prod_q <= '0;
    else
    begin
      case (step)
        STEP_LOAD:  prod_q <= {1'b0, {WIDTH{1'b0}}, multiplier}; // high half starts at zero
        STEP_ADD:   prod_q[2*WIDTH:WIDTH] <= sum;  // low half is left alone
        STEP_SHIFT: prod_q <= {1'b0, prod_q[PW-1:1]}; // carry drops into the partial sum
        default:    prod_q <= prod_q;
      endcase
    end
  end

  // multiplicand is payload and only matters from the load onward
  always_ff @(posedge doMult)
  begin
    if (step == STEP_LOAD)
      mcand_q <= multiplicand;
  end

  // after WIDTH add and shift pairs the carry bit is back to zero
  // and the lower 2*WIDTH bits hold the full product
  assign product = prod_q[2*WIDTH-1:0];

endmodule

/* source/multu_top.sv */
// multu top level tying the handshake block, the shift-add control and the datapath
`timescale 1ns/1ps

module multu_top
  import multu_pkg::*;
#(
  parameter int WIDTH = multu_width_default // operand width in bits
)
(
  input  logic               doMult,       // clock for every register in the design
  input  logic               rst_n,        // asynchronous reset, active low
  input  logic               req,          // four-phase request from the outside
  input  logic [WIDTH-1:0]   multiplicand, // held stable by the outside while req is high
  input  logic [WIDTH-1:0]   multiplier,
  output logic               ack,          // product is valid while this is high
  output logic [2*WIDTH-1:0] product
);

  logic             start;      // one cycle pulse that launches a multiply
  logic             done;       // level from the control once all shifts are over
  multu_step_e      step;       // opcode from the control to the datapath
  logic [WIDTH-1:0] op_mcand;   // operands as captured by the request block
  logic [WIDTH-1:0] op_mplier;

  // handshake and operand capture
  multu_request_regs #(
    .WIDTH (WIDTH)
  ) u_request_regs (
    .doMult          (doMult),
    .rst_n           (rst_n),
    .req             (req),
    .multiplicand_in (multiplicand),
    .multiplier_in   (multiplier),
    .done            (done),
    .ack             (ack),
    .start           (start),
    .multiplicand    (op_mcand),
    .multiplier      (op_mplier)
  );

  // the control counts one shift per operand bit so it gets the same width
  multu_control #(
    .WIDTH (WIDTH)
  ) u_control (
    .doMult (doMult),
    .rst_n  (rst_n),
    .start  (start),
    .step   (step),
    .done   (done)
  );

  multu_datapath #(
    .WIDTH (WIDTH)
  ) u_datapath (
    .doMult       (doMult),
    .rst_n        (rst_n),
    .step         (step),
    .multiplicand (op_mcand),
    .multiplier   (op_mplier),
    .product      (product)
  );

endmodule

/* bench/multu_clock_gen.sv */
// multu testbench clock and reset generator with a free running clock and a short reset
`timescale 1ns/1ps

module multu_clock_gen
#(
  parameter int PERIOD_NS    = 40, // full clock period
  parameter int RESET_CYCLES = 3   // rising edges with reset held low
)
(
  output logic doMult,
  output logic rst_n
);

  initial
  begin
    doMult = 1'b0;
    forever #(PERIOD_NS / 2) doMult = ~doMult;
  end

  // reset is released on a rising edge like any other stimulus
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge doMult);
    rst_n <= 1'b1;
  end

endmodule

/* bench/multu_tb.sv */
// multu self-checking testbench running file vectors, random operands and handshake checks
`timescale 1ns/1ps

module multu_tb
  import multu_pkg::*;
();

  localparam int W        = multu_width_default;
  localparam int NUM_FILE = 26;  // vectors in the data file
  localparam int NUM_RAND = 12;  // operand pairs drawn from the lfsr
  localparam int LATENCY  = 2 * W + 4; // edges from req sampled high to ack high

  // every multiply fits well inside one slot and the extra slots cover reset and back-pressure
  localparam int TIMEOUT_CYCLES = (NUM_FILE + NUM_RAND + 8) * (2 * W + 12);

  logic           doMult;
  logic           rst_n;
  logic           req;
  logic [W-1:0]   multiplicand;
  logic [W-1:0]   multiplier;
  logic           ack;
  logic [2*W-1:0] product;

  logic [2*W-1:0] vec_mem [0:3*NUM_FILE-1]; // multiplicand, multiplier, product per vector
  logic [31:0]    lfsr_state;
  int             cycle_count;

  multu_clock_gen #(
    .PERIOD_NS    (40),
    .RESET_CYCLES (3)
  ) u_clock_gen (
    .doMult (doMult),
    .rst_n  (rst_n)
  );

  multu_top #(
    .WIDTH (W)
  ) UUT (
    .doMult       (doMult),
    .rst_n        (rst_n),
    .req          (req),
    .multiplicand (multiplicand),
    .multiplier   (multiplier),
    .ack          (ack),
    .product      (product)
  );

  // prints why the run ends and stops at once
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input logic [2*W-1:0] actual, input logic [2*W-1:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("FAIL at %0d ns: %s, got %h expected %h", $time, what, actual, expected);
      abort_run("a checked value did not match its expected value");
    end
  endtask

  // galois form of x^32 + x^22 + x^2 + x + 1 that shifts right
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
      n = n ^ 32'h8020_0003;
    return n;
  endfunction

  // one lfsr step for every operand bit
  task automatic draw_operand(output logic [W-1:0] value);
    for (int i = 0; i < W; i++)
    begin
      value[i]   = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // one full four-phase transfer with req kept high for hold_cycles after ack
  task automatic run_request(input logic [W-1:0] a, input logic [W-1:0] b,
                             input int hold_cycles, output logic [2*W-1:0] result);
    int edges;
    @(posedge doMult);
    req          <= 1'b1;
    multiplicand <= a;
    multiplier   <= b;
    @(posedge doMult); // the DUT sees req high on this edge
    edges = 0;
    @(negedge doMult);
    while (!ack) // a hang here ends in the timeout
    begin
      edges++;
      @(negedge doMult);
    end
    check_value(edges, LATENCY, "edges from req sampled high to ack");
    result = product;
    for (int k = 0; k < hold_cycles; k++)
    begin
      @(negedge doMult);
      check_value(ack, 1'b1, "ack while req is held high");
      check_value(product, result, "product while req is held high");
    end
    @(posedge doMult);
    req <= 1'b0;
    @(negedge doMult); // req is low but not yet sampled
    check_value(ack, 1'b1, "ack before req low is sampled");
    check_value(product, result, "product while ack is high");
    @(negedge doMult);
    check_value(ack, 1'b0, "ack one edge after req sampled low");
  endtask

  // cycle budget for the whole run
  always @(posedge doMult)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
      abort_run("timeout: the run took more cycles than the tests should need");
  end

  initial
  begin
    logic [W-1:0]   a;
    logic [W-1:0]   b;
    logic [2*W-1:0] expected;
    logic [2*W-1:0] result;
    logic [2*W-1:0] first_result;

    req          = 1'b0;
    multiplicand = '0;
    multiplier   = '0;
    cycle_count  = 0;
    lfsr_state   = 32'hfbbe;
    $readmemh("bench/multu_testdata.txt", vec_mem);

    for (int i = 0; i < 3 * NUM_FILE; i++)
    begin
      if ($isunknown(vec_mem[i]))
        abort_run("the test data file is missing or holds fewer vectors than expected");
    end

    wait (rst_n === 1'b1);

    // ack must stay low on an idle bus after reset
    for (int i = 0; i < 5; i++)
    begin
      @(negedge doMult);
      check_value(ack, 1'b0, "ack with req low after reset");
    end

    // file vectors back to back with each one on its own operands
    for (int i = 0; i < NUM_FILE; i++)
    begin
      a        = vec_mem[3*i][W-1:0];
      b        = vec_mem[3*i+1][W-1:0];
      expected = vec_mem[3*i+2];
      run_request(a, b, 0, result);
      check_value(result, expected, $sformatf("file vector %0d product", i));
    end

    // random operands checked against a plain wide multiply
    for (int i = 0; i < NUM_RAND; i++)
    begin
      draw_operand(a);
      draw_operand(b);
      expected = {{W{1'b0}}, a} * {{W{1'b0}}, b};
      run_request(a, b, 0, result);
      check_value(result, expected, $sformatf("random vector %0d product", i));
    end

    // back-pressure with req held 20 cycles past ack
    a = 32'hc0de_1234;
    b = 32'h0000_fffd;
    expected = {{W{1'b0}}, a} * {{W{1'b0}}, b};
    run_request(a, b, 20, first_result);
    check_value(first_result, expected, "product under back-pressure");

    // the next request must not see anything of the held one
    a = 32'h0000_0007;
    b = 32'h0000_0003;
    run_request(a, b, 0, result);
    check_value(result, 64'd21, "product after back-pressure");

    $display("all tests passed");
    $finish;
  end

endmodule

/* multu_top.f */
source/multu_pkg.sv
source/multu_request_regs.sv
source/multu_control.sv
source/multu_datapath.sv
source/multu_top.sv
bench/multu_clock_gen.sv
bench/multu_tb.sv

/* bench/multu_testdata.txt */
// columns: multiplicand multiplier expected_product, all in hex
// one vector per line, width 32 x 32 giving 64 bits
00000000 00000000 0000000000000000
00000000 ffffffff 0000000000000000
ffffffff 00000000 0000000000000000
00000001 00000001 0000000000000001
ffffffff 00000001 00000000ffffffff
00000001 ffffffff 00000000ffffffff
ffffffff ffffffff fffffffe00000001
80000000 80000000 4000000000000000
80000000 00000002 0000000100000000
00010000 00010000 0000000100000000
00000002 00000004 0000000000000008
80000000 ffffffff 7fffffff80000000
ffffffff 00000002 00000001fffffffe
0000ffff 0000ffff 00000000fffe0001
00000003 00000005 000000000000000f
0000000a 0000000a 0000000000000064
12345678 00000010 0000000123456780
00001000 00100000 0000000100000000
aaaaaaaa 00000002 0000000155555554
55555555 00000003 00000000ffffffff
7fffffff 7fffffff 3fffffff00000001
00000100 00000100 0000000000010000
ffff0000 0000ffff 0000fffe00010000
deadbeef 00000001 00000000deadbeef
00000001 80000000 0000000080000000
40000000 00000004 0000000100000000
